// ==== hdl/layer7_fc_pkg.sv ====
package layer7_fc_pkg;

	// Lane and word geometry of the weight SRAM
	localparam int weight_w = 16;	// One signed weight or activation
	localparam int lanes = 8;	// Lanes per word
	localparam int word_w = 128;	// SRAM word, lanes * weight_w
	localparam int addr_w = 6;	// 64 words deep

	// Counter used for read and write word addresses
	localparam int cnt_w = 16;

	// Layer 7 shape: 2 neurons x 200 weights
	localparam int row_words = 25;	// Words per neuron, also port A offset
	localparam int weight_words = 50;	// Write counter wraps after this many

	// Datapath growth
	localparam int prod_w = 32;	// 16 x 16 signed product
	localparam int sum_w = 35;	// Eight products summed, 3 extra bits
	localparam int acc_w = 40;	// 25 partial sums, with headroom

endpackage

// ==== hdl/counter_cnn.sv ====
`timescale 1ns/1ps

module counter_cnn (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           clear,	// Back to zero, wins over keep
	input  logic                           keep,	// Hold current value
	output logic [layer7_fc_pkg::cnt_w-1:0] count
);

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			count <= '0;
		end
		else if (clear)
		begin
			count <= '0;	// Wrap point set by caller
		end
		else if (!keep)
		begin
			count <= count + 1'b1;	// Advance one word
		end
	end

endmodule

// ==== hdl/weight_sram_64x128.sv ====
`timescale 1ns/1ps

module weight_sram_64x128 (
	input  logic                            clk,
	input  logic                            oea,	// Port A read enable
	input  logic                            oeb,	// Port B read enable
	input  logic [layer7_fc_pkg::lanes-1:0]  wean,	// Port A lane writes, active low
	input  logic [layer7_fc_pkg::lanes-1:0]  webn,	// Port B lane writes, active low
	input  logic [layer7_fc_pkg::addr_w-1:0] a,
	input  logic [layer7_fc_pkg::addr_w-1:0] b,
	input  logic [layer7_fc_pkg::word_w-1:0] dia,
	input  logic [layer7_fc_pkg::word_w-1:0] dib,
	output logic [layer7_fc_pkg::word_w-1:0] doa,
	output logic [layer7_fc_pkg::word_w-1:0] dob
);

	import layer7_fc_pkg::*;

	logic [word_w-1:0] mem [1 << addr_w];	// 64 words of 128 bits

	// Port A, lane writes and registered read
	always_ff @(posedge clk)
	begin
		for (int l = 0; l < lanes; l++)
		begin
			if (!wean[l])
				mem[a][l*weight_w +: weight_w] <= dia[l*weight_w +: weight_w];
		end
		if (oea)
			doa <= mem[a];	// Old data on a same-address write
	end

	// Port B, same behavior
	always_ff @(posedge clk)
	begin
		for (int l = 0; l < lanes; l++)
		begin
			if (!webn[l])
				mem[b][l*weight_w +: weight_w] <= dib[l*weight_w +: weight_w];
		end
		if (oeb)
			dob <= mem[b];	// Holds while oeb low
	end

endmodule

// ==== hdl/layer7_local_mem_weight.sv ====
`timescale 1ns/1ps

module layer7_local_mem_weight (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              read_weight_signal,	// One read per act word
	input  logic [layer7_fc_pkg::cnt_w-1:0]    read_weight_addr1,	// Neuron 0 word, port B
	input  logic [layer7_fc_pkg::cnt_w-1:0]    read_weight_addr2,	// Neuron 1 word, port A
	input  logic                              write_weight_signal,	// One weight per cycle
	input  logic [layer7_fc_pkg::weight_w-1:0] write_weight_data,
	output logic [layer7_fc_pkg::word_w-1:0]   read_weight_data1,	// Neuron 0 weights
	output logic [layer7_fc_pkg::word_w-1:0]   read_weight_data2	// Neuron 1 weights
);

	import layer7_fc_pkg::*;

	logic [$clog2(lanes)-1:0] lane_state;	// Lane to fill next
	logic [$clog2(lanes)-1:0] lane_state_ns;
	logic                     last_lane;	// Lane 7 being written

	logic [cnt_w-1:0]  write_addr;	// Word being filled
	logic              write_addr_clear;
	logic              write_addr_keep;
	logic [lanes-1:0]  write_web;	// Active-low lane enables
	logic [word_w-1:0] write_data;

	logic              read_enable;
	logic [addr_w-1:0] addr_a_sram;	// Shared by write and neuron 1 read
	logic [addr_w-1:0] addr_b_sram;

	// Word address for the load side
	counter_cnn u_write_count (
		.clk   (clk),
		.rst   (rst),
		.clear (write_addr_clear),
		.keep  (write_addr_keep),
		.count (write_addr)
	);

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			lane_state <= '0;
		end
		else
		begin
			lane_state <= lane_state_ns;
		end
	end

	always_comb
	begin
		last_lane = (lane_state == $clog2(lanes)'(lanes - 1));

		if (write_weight_signal)
		begin
			lane_state_ns = lane_state + 1'b1;	// 7 rolls over to 0
			write_web = ~(lanes'(1) << lane_state);	// Only the current lane low
			write_addr_keep = !last_lane;	// Next word after lane 7
			write_addr_clear = last_lane && (write_addr == cnt_w'(weight_words - 1));
		end
		else
		begin
			lane_state_ns = lane_state;	// Idle, lane holds
			write_web = '1;
			write_addr_keep = 1'b1;
			write_addr_clear = 1'b0;
		end

		// Same weight on every lane, the enable picks one
		write_data = {lanes{write_weight_data}};
	end

	always_comb
	begin
		read_enable = read_weight_signal;

		// Writes own port A, reads add the neuron 1 offset
		if (write_weight_signal)
			addr_a_sram = write_addr[addr_w-1:0];
		else
			addr_a_sram = read_weight_addr2[addr_w-1:0] + addr_w'(row_words);

		addr_b_sram = read_weight_addr1[addr_w-1:0];	// Read only port
	end

	weight_sram_64x128 u_weight_sram (
		.clk  (clk),
		.oea  (read_enable),
		.oeb  (read_enable),
		.wean (write_web),
		.webn ('1),	// Port B never writes
		.a    (addr_a_sram),
		.b    (addr_b_sram),
		.dia  (write_data),
		.dib  ('0),
		.doa  (read_weight_data2),
		.dob  (read_weight_data1)
	);

endmodule

// ==== hdl/layer7_read_sequencer.sv ====
`timescale 1ns/1ps

module layer7_read_sequencer (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            act_valid,	// One strobe per act word
	input  logic [layer7_fc_pkg::word_w-1:0] act_data,
	output logic                            read_weight_signal,
	output logic [layer7_fc_pkg::cnt_w-1:0]  read_addr,	// Word index 0..24
	output logic [layer7_fc_pkg::word_w-1:0] act_word,	// Lines up with SRAM data
	output logic                            word_valid,
	output logic                            word_last
);

	import layer7_fc_pkg::*;

	logic last;	// 25th word of the vector

	assign last = act_valid && (read_addr == cnt_w'(row_words - 1));
	assign read_weight_signal = act_valid;	// Read in the same cycle

	// Word index within the vector
	counter_cnn u_read_count (
		.clk   (clk),
		.rst   (rst),
		.clear (last),	// Next vector starts at 0
		.keep  (!act_valid),
		.count (read_addr)
	);

	// SRAM output is one edge late, delay act side to match
	always_ff @(posedge clk)
	begin
		act_word <= act_data;
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			word_valid <= 1'b0;
			word_last <= 1'b0;
		end
		else
		begin
			word_valid <= act_valid;
			word_last <= last;
		end
	end

endmodule

// ==== hdl/layer7_dot_product.sv ====
`timescale 1ns/1ps

module layer7_dot_product (
	input  logic                                clk,
	input  logic                                rst,
	input  logic        [layer7_fc_pkg::word_w-1:0] act_word,	// Eight activations
	input  logic        [layer7_fc_pkg::word_w-1:0] weight0,	// Neuron 0 lanes
	input  logic        [layer7_fc_pkg::word_w-1:0] weight1,	// Neuron 1 lanes
	input  logic                                word_valid,
	input  logic                                word_last,
	output logic signed [layer7_fc_pkg::sum_w-1:0]  sum0,
	output logic signed [layer7_fc_pkg::sum_w-1:0]  sum1,
	output logic                                sum_valid,
	output logic                                sum_last
);

	import layer7_fc_pkg::*;

	logic        [word_w-1:0] weight [2];	// Indexed by neuron
	logic signed [prod_w-1:0] prod [2][lanes];	// Stage one
	logic signed [sum_w-1:0]  lane_sum [2];	// Adder tree input to stage two
	logic signed [sum_w-1:0]  sum_q [2];
	logic                     prod_valid;
	logic                     prod_last;

	always_comb
	begin
		weight[0] = weight0;
		weight[1] = weight1;
	end

	// Stage one, 16 signed multiplies
	always_ff @(posedge clk)
	begin
		for (int n = 0; n < 2; n++)
		begin
			for (int l = 0; l < lanes; l++)
			begin
				prod[n][l] <= $signed(weight[n][l*weight_w +: weight_w])
					* $signed(act_word[l*weight_w +: weight_w]);
			end
		end
	end

	// Sum eight products per neuron
	always_comb
	begin
		for (int n = 0; n < 2; n++)
		begin
			lane_sum[n] = '0;
			for (int l = 0; l < lanes; l++)
				lane_sum[n] = lane_sum[n] + sum_w'(prod[n][l]);	// Sign extended
		end
	end

	// Stage two
	always_ff @(posedge clk)
	begin
		for (int n = 0; n < 2; n++)
			sum_q[n] <= lane_sum[n];
	end

	assign sum0 = sum_q[0];
	assign sum1 = sum_q[1];

	// Flags ride along with the data
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			prod_valid <= 1'b0;
			prod_last <= 1'b0;
			sum_valid <= 1'b0;
			sum_last <= 1'b0;
		end
		else
		begin
			prod_valid <= word_valid;
			prod_last <= word_last;
			sum_valid <= prod_valid;
			sum_last <= prod_last;
		end
	end

endmodule

// ==== hdl/layer7_accumulator.sv ====
`timescale 1ns/1ps

module layer7_accumulator (
	input  logic                               clk,
	input  logic                               rst,
	input  logic signed [layer7_fc_pkg::sum_w-1:0] sum0,	// Partial sum, neuron 0
	input  logic signed [layer7_fc_pkg::sum_w-1:0] sum1,	// Partial sum, neuron 1
	input  logic                               sum_valid,
	input  logic                               sum_last,	// 25th partial sum
	output logic signed [layer7_fc_pkg::acc_w-1:0] result0,
	output logic signed [layer7_fc_pkg::acc_w-1:0] result1,
	output logic                               result_valid	// One cycle per vector
);

	import layer7_fc_pkg::*;

	logic signed [acc_w-1:0] acc0;	// Running totals
	logic signed [acc_w-1:0] acc1;
	logic signed [acc_w-1:0] base0;	// Zero on the first word
	logic signed [acc_w-1:0] base1;
	logic signed [acc_w-1:0] next0;
	logic signed [acc_w-1:0] next1;
	logic                    restart;	// Next valid sum opens a new vector

	always_comb
	begin
		base0 = restart ? '0 : acc0;
		base1 = restart ? '0 : acc1;
		next0 = base0 + acc_w'(sum0);
		next1 = base1 + acc_w'(sum1);
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			acc0 <= '0;
			acc1 <= '0;
			restart <= 1'b1;	// First word after reset starts fresh
			result0 <= '0;
			result1 <= '0;
			result_valid <= 1'b0;
		end
		else
		begin
			result_valid <= sum_valid && sum_last;
			if (sum_valid)
			begin
				acc0 <= next0;
				acc1 <= next1;
				restart <= sum_last;
				if (sum_last)
				begin
					result0 <= next0;	// Held until next strobe
					result1 <= next1;
				end
			end
		end
	end

endmodule

// ==== hdl/layer7_fc_top.sv ====
`timescale 1ns/1ps

module layer7_fc_top (
	input  logic                                clk,
	input  logic                                rst,
	input  logic                                write_weight_signal,	// Weight load level
	input  logic        [layer7_fc_pkg::weight_w-1:0] write_weight_data,
	input  logic                                act_valid,	// Act word strobe
	input  logic        [layer7_fc_pkg::word_w-1:0]   act_data,
	output logic                                result_valid,
	output logic signed [layer7_fc_pkg::acc_w-1:0]    result0,
	output logic signed [layer7_fc_pkg::acc_w-1:0]    result1
);

	import layer7_fc_pkg::*;

	logic                     read_weight_signal;
	logic        [cnt_w-1:0]  read_addr;	// Same index for both neurons
	logic        [word_w-1:0] act_word;
	logic                     word_valid;
	logic                     word_last;
	logic        [word_w-1:0] read_weight_data1;
	logic        [word_w-1:0] read_weight_data2;
	logic signed [sum_w-1:0]  sum0;
	logic signed [sum_w-1:0]  sum1;
	logic                     sum_valid;
	logic                     sum_last;

	layer7_read_sequencer u_seq (
		.clk                (clk),
		.rst                (rst),
		.act_valid          (act_valid),
		.act_data           (act_data),
		.read_weight_signal (read_weight_signal),
		.read_addr          (read_addr),
		.act_word           (act_word),
		.word_valid         (word_valid),
		.word_last          (word_last)
	);

	layer7_local_mem_weight u_mem (
		.clk                 (clk),
		.rst                 (rst),
		.read_weight_signal  (read_weight_signal),
		.read_weight_addr1   (read_addr),
		.read_weight_addr2   (read_addr),	// Offset added inside
		.write_weight_signal (write_weight_signal),
		.write_weight_data   (write_weight_data),
		.read_weight_data1   (read_weight_data1),
		.read_weight_data2   (read_weight_data2)
	);

	layer7_dot_product u_dot (
		.clk        (clk),
		.rst        (rst),
		.act_word   (act_word),
		.weight0    (read_weight_data1),
		.weight1    (read_weight_data2),
		.word_valid (word_valid),
		.word_last  (word_last),
		.sum0       (sum0),
		.sum1       (sum1),
		.sum_valid  (sum_valid),
		.sum_last   (sum_last)
	);

	layer7_accumulator u_acc (
		.clk          (clk),
		.rst          (rst),
		.sum0         (sum0),
		.sum1         (sum1),
		.sum_valid    (sum_valid),
		.sum_last     (sum_last),
		.result0      (result0),
		.result1      (result1),
		.result_valid (result_valid)
	);

endmodule

// ==== testbench/layer7_fc_checker.sv ====
`timescale 1ns/1ps

module layer7_fc_checker (
	input  logic                                      clk,
	input  logic                                      rst,
	input  logic                                      write_weight_signal,
	input  logic        [layer7_fc_pkg::weight_w-1:0] write_weight_data,
	input  logic                                      act_valid,
	input  logic        [layer7_fc_pkg::word_w-1:0]   act_data,
	input  logic                                      result_valid,
	input  logic signed [layer7_fc_pkg::acc_w-1:0]    result0,
	input  logic signed [layer7_fc_pkg::acc_w-1:0]    result1,
	output int                                        pass_count,
	output int                                        fail_count,
	output int                                        pending	// Vectors still owed a result
);

	import layer7_fc_pkg::*;

	localparam int n_weights = 2 * row_words * lanes;	// 400, both neurons
	localparam int row_weights = row_words * lanes;	// 200 per neuron

	logic signed [weight_w-1:0] weight_model [n_weights];
	logic        [word_w-1:0]   vec [row_words];	// Vector being captured
	int                         weight_count = 0;	// Weights since reset
	int                         word_count = 0;
	int                         cycle = 0;	// Rising edges seen
	int                         checked = 0;
	longint                     exp0_q [$];
	longint                     exp1_q [$];
	int                         due_q [$];	// Cycle the strobe belongs to

	// Weight k sits in word k/8, lane k%8
	function automatic longint dot_model(int n);
		longint acc;
		logic signed [weight_w-1:0] a;
		acc = 0;
		for (int j = 0; j < row_weights; j++)
		begin
			a = vec[j / lanes][(j % lanes)*weight_w +: weight_w];
			acc += longint'(weight_model[n*row_weights + j]) * longint'(a);
		end
		return acc;
	endfunction

	task automatic check_pair();
		logic signed [acc_w-1:0] e0;
		logic signed [acc_w-1:0] e1;
		int due;
		bit ok;
		e0 = acc_w'(exp0_q.pop_front());
		e1 = acc_w'(exp1_q.pop_front());
		due = due_q.pop_front();
		ok = 1'b1;
		if (result0 !== e0)
		begin
			$display("ERROR at %0t ns: result0 got %0d expected %0d", $time, result0, e0);
			ok = 1'b0;
		end
		if (result1 !== e1)
		begin
			$display("ERROR at %0t ns: result1 got %0d expected %0d", $time, result1, e1);
			ok = 1'b0;
		end
		if (cycle != due)	// Strobe in the 4th cycle after last word
		begin
			$display("ERROR at %0t ns: result_valid cycle got %0d expected %0d",
				$time, cycle, due);
			ok = 1'b0;
		end
		checked++;
		if (ok)
			pass_count++;
		else
			fail_count++;
		$display("Vector %0d: %s", checked, ok ? "pass" : "fail");
	endtask

	initial
	begin
		pass_count = 0;
		fail_count = 0;
		pending = 0;
	end

	// Inputs change on the falling edge, sample them on the rising one
	always @(posedge clk)
	begin
		cycle = cycle + 1;
		if (rst)
		begin
			weight_count = 0;
			word_count = 0;
		end
		else
		begin
			if (write_weight_signal)
			begin
				weight_model[weight_count % n_weights] = write_weight_data;	// Wraps like the SRAM
				weight_count++;
			end
			if (act_valid)
			begin
				vec[word_count] = act_data;
				word_count++;
				if (word_count == row_words)
				begin
					exp0_q.push_back(dot_model(0));
					exp1_q.push_back(dot_model(1));
					due_q.push_back(cycle + 3);	// Four registers, last one loads 3 edges on
					word_count = 0;
				end
			end
		end
		pending = exp0_q.size();
	end

	// Outputs settle after the rising edge
	always @(negedge clk)
	begin
		if (!rst && result_valid)
		begin
			if (exp0_q.size() == 0)
			begin
				$display("At %0t ns result_valid pulsed with no completed vector pending", $time);
				fail_count++;
			end
			else
				check_pair();
		end
		pending = exp0_q.size();
	end

endmodule

// ==== testbench/tb_layer7_fc.sv ====
`timescale 1ns/1ps

module tb_layer7_fc;

	import layer7_fc_pkg::*;

	localparam int n_entries = 14;
	localparam int kind_load = 0;
	localparam int kind_run = 1;
	localparam int pat_random = 0;
	localparam int pat_min = 1;	// All 16'h8000
	localparam int pat_alt = 2;	// 7fff and 8000 alternating
	localparam int pat_ramp = 3;
	localparam int pat_repeat = 4;	// Previous vector again
	localparam int gap_random = -1;	// 1 to 3 idle cycles per word
	localparam int result_timeout = 200;

	// Columns: kind, pattern, idle cycles between strobes, chain into next run
	localparam int stim_table [n_entries][4] = '{
		'{kind_load, pat_random, 0, 0},
		'{kind_run,  pat_random, 0, 0},
		'{kind_load, pat_min,    0, 0},
		'{kind_run,  pat_min,    0, 0},
		'{kind_load, pat_alt,    0, 0},
		'{kind_run,  pat_alt,    0, 0},
		'{kind_load, pat_random, 0, 0},
		'{kind_run,  pat_random, 0, 1},	// Back to back with the next one
		'{kind_run,  pat_ramp,   0, 0},
		'{kind_run,  pat_random, 0, 0},
		'{kind_run,  pat_repeat, 2, 0},
		'{kind_run,  pat_repeat, gap_random, 0},
		'{kind_load, pat_ramp,   0, 0},	// Overwrites after the wrap
		'{kind_run,  pat_random, 0, 0}
	};

	logic                       clk;
	logic                       rst;
	logic                       write_weight_signal;
	logic        [weight_w-1:0] write_weight_data;
	logic                       act_valid;
	logic        [word_w-1:0]   act_data;
	logic                       result_valid;
	logic signed [acc_w-1:0]    result0;
	logic signed [acc_w-1:0]    result1;
	int                         pass_count;
	int                         fail_count;
	int                         pending;
	logic        [word_w-1:0]   saved_vec [row_words];	// Kept for repeat runs

	layer7_fc_top dut0 (
		.clk                 (clk),
		.rst                 (rst),
		.write_weight_signal (write_weight_signal),
		.write_weight_data   (write_weight_data),
		.act_valid           (act_valid),
		.act_data            (act_data),
		.result_valid        (result_valid),
		.result0             (result0),
		.result1             (result1)
	);

	layer7_fc_checker chk0 (
		.clk                 (clk),
		.rst                 (rst),
		.write_weight_signal (write_weight_signal),
		.write_weight_data   (write_weight_data),
		.act_valid           (act_valid),
		.act_data            (act_data),
		.result_valid        (result_valid),
		.result0             (result0),
		.result1             (result1),
		.pass_count          (pass_count),
		.fail_count          (fail_count),
		.pending             (pending)
	);

	function automatic logic [weight_w-1:0] lane_value(int pattern, int idx);
		case (pattern)
			pat_min: return 16'h8000;
			pat_alt: return (idx % 2) ? 16'h8000 : 16'h7fff;
			pat_ramp: return weight_w'(idx * 131 - 26000);	// Crosses zero
			default: return weight_w'($urandom);
		endcase
	endfunction

	task automatic load_weights(int pattern);
		for (int k = 0; k < 2 * row_words * lanes; k++)
		begin
			@(negedge clk);
			write_weight_signal = 1'b1;
			write_weight_data = lane_value(pattern, k);
		end
		@(negedge clk);
		write_weight_signal = 1'b0;
	endtask

	// Leaves act_valid high after the 25th word
	task automatic send_vector(int pattern, int gap);
		int idle;
		for (int i = 0; i < row_words; i++)
		begin
			if (pattern != pat_repeat)
			begin
				for (int l = 0; l < lanes; l++)
					saved_vec[i][l*weight_w +: weight_w] = lane_value(pattern, i*lanes + l);
			end
			@(negedge clk);
			act_valid = 1'b1;
			act_data = saved_vec[i];
			idle = (gap == gap_random) ? $urandom_range(3, 1) : gap;
			if (i < row_words - 1)	// Gaps only between strobes
			begin
				repeat (idle)
				begin
					@(negedge clk);
					act_valid = 1'b0;
				end
			end
		end
	endtask

	task automatic wait_results(output bit ok);
		int t;
		t = 0;
		while (pending != 0 && t < result_timeout)
		begin
			@(posedge clk);
			t++;
		end
		ok = (pending == 0);
	endtask

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial
	begin
		bit ok;
		bit timed_out;
		void'($urandom(66385));
		timed_out = 1'b0;
		rst = 1'b1;
		write_weight_signal = 1'b0;
		write_weight_data = '0;
		act_valid = 1'b0;
		act_data = '0;
		repeat (3) @(posedge clk);	// Three rising edges in reset
		@(negedge clk);
		rst = 1'b0;
		repeat (5) @(negedge clk);	// Idle, no strobe allowed yet
		for (int e = 0; e < n_entries; e++)
		begin
			if (stim_table[e][0] == kind_load)
				load_weights(stim_table[e][1]);
			else
			begin
				send_vector(stim_table[e][1], stim_table[e][2]);
				if (stim_table[e][3] == 0)
				begin
					@(negedge clk);
					act_valid = 1'b0;
					wait_results(ok);
					if (!ok)
					begin
						$display("Timeout: no result arrived for table entry %0d", e);
						timed_out = 1'b1;
						break;
					end
				end
			end
		end
		repeat (10) @(negedge clk);	// Catch late or stray strobes
		$display("Checks: %0d passed, %0d failed", pass_count, fail_count);
		if (fail_count == 0 && !timed_out && pending == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// ==== list.f ====
hdl/layer7_fc_pkg.sv
hdl/counter_cnn.sv
hdl/weight_sram_64x128.sv
hdl/layer7_local_mem_weight.sv
hdl/layer7_read_sequencer.sv
hdl/layer7_dot_product.sv
hdl/layer7_accumulator.sv
hdl/layer7_fc_top.sv
testbench/layer7_fc_checker.sv
testbench/tb_layer7_fc.sv

// ==== Bender.yml ====
package:
  name: layer7_fc

sources:
  - hdl/layer7_fc_pkg.sv
  - hdl/counter_cnn.sv
  - hdl/weight_sram_64x128.sv
  - hdl/layer7_local_mem_weight.sv
  - hdl/layer7_read_sequencer.sv
  - hdl/layer7_dot_product.sv
  - hdl/layer7_accumulator.sv
  - hdl/layer7_fc_top.sv
  - target: test
    files:
      - testbench/layer7_fc_checker.sv
      - testbench/tb_layer7_fc.sv
